// File: rtl/riscv_rf_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, debug address map and debug FSM encoding
// Register file is fixed at 32 entries of XLEN bits
// Debug space is 12 bits wide and GPRs occupy 0x000..0x01F
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package riscv_rf_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////////////////////////////

  // Integer register width
  localparam int XLEN    = 32;
  // Register index width
  localparam int AR_BITS = 5;
  // Number of general registers
  localparam int NREGS   = 32;

  //////////////////////////////////////////////////////////////////////////
  // Debug address map
  //////////////////////////////////////////////////////////////////////////

  localparam int DU_ADDR_BITS = 12;

  // Address of x0 in debug space
  // Upper bits above AR_BITS select the GPR group
  localparam logic [DU_ADDR_BITS-1:0] DU_GPR_BASE = 12'h000;

  // Debug access FSM
  typedef enum logic [1:0] {
    DU_IDLE   = 2'd0,
    DU_DRAIN  = 2'd1,
    DU_ACCESS = 2'd2,
    DU_ACK    = 2'd3
  } du_state_t;

endpackage

`default_nettype wire

// File: rtl/riscv_du_rf_if.sv
////////////////////////////////////////////////////////////////////////////
// Debug port between the debug access unit and the register file
// du_dati_rf is a combinational read of du_addr, zero for x0
// du_stall is carried for the core side only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface riscv_du_rf_if;
  import riscv_rf_pkg::*;

  // Stall level toward the core
  logic               du_stall;
  // One-cycle write strobe
  logic               du_we_rf;
  // Register index
  logic [AR_BITS-1:0] du_addr;
  // Write data from debug unit
  logic [XLEN-1:0]    du_dato;
  // Read data from register file
  logic [XLEN-1:0]    du_dati_rf;

  // Debug unit side
  modport du (
    output du_stall,
    output du_we_rf,
    output du_addr,
    output du_dato,
    input  du_dati_rf
  );

  // Register file side, mirror of du
  modport rf (
    input  du_stall,
    input  du_we_rf,
    input  du_addr,
    input  du_dato,
    output du_dati_rf
  );

endinterface

`default_nettype wire

// File: rtl/riscv_rf.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file, 32 x XLEN
// Two operand reads with one cycle latency, no write bypass
// A read and a write of the same register at one edge returns old data
// Debug write wins over a core write in the same cycle
// Array contents are not cleared by reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module riscv_rf (
  input  logic                             clk,
  input  logic                             rst_n,

  // Operand reads
  input  logic [riscv_rf_pkg::AR_BITS-1:0] rf_src1,
  input  logic [riscv_rf_pkg::AR_BITS-1:0] rf_src2,
  output logic [riscv_rf_pkg::XLEN-1:0]    rf_srcv1,
  output logic [riscv_rf_pkg::XLEN-1:0]    rf_srcv2,

  // Write-back
  input  logic [riscv_rf_pkg::AR_BITS-1:0] rf_dst,
  input  logic [riscv_rf_pkg::XLEN-1:0]    rf_dstv,
  input  logic                             rf_we,

  // Debug port
  riscv_du_rf_if.rf                        du
);
  import riscv_rf_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////

  // Register array
  logic [XLEN-1:0] regs [NREGS];

  // Registered array data per operand
  logic [XLEN-1:0] dout1;
  logic [XLEN-1:0] dout2;

  // Sampled address was x0
  logic            src1_is_x0;
  logic            src2_is_x0;

  //////////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////////

  // Debug strobe first, core write dropped on collision
  always_ff @(posedge clk) begin
    if (du.du_we_rf) begin
      regs[du.du_addr] <= du.du_dato;
    end else if (rf_we) begin
      regs[rf_dst] <= rf_dstv;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Operand reads
  //////////////////////////////////////////////////////////////////////////

  // Array data sampled with the address
  // Old contents seen when a write lands on the same edge
  always_ff @(posedge clk) begin
    dout1 <= regs[rf_src1];
    dout2 <= regs[rf_src2];
  end

  // x0 flags, forced after reset so outputs start at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src1_is_x0 <= 1'b1;
      src2_is_x0 <= 1'b1;
    end else begin
      src1_is_x0 <= (rf_src1 == '0);
      src2_is_x0 <= (rf_src2 == '0);
    end
  end

  // Writes to x0 are stored but masked here
  assign rf_srcv1 = src1_is_x0 ? '0 : dout1;
  assign rf_srcv2 = src2_is_x0 ? '0 : dout2;

  //////////////////////////////////////////////////////////////////////////
  // Debug read
  //////////////////////////////////////////////////////////////////////////

  // Combinational, zero for x0
  assign du.du_dati_rf = (du.du_addr == '0) ? '0 : regs[du.du_addr];

endmodule

`default_nettype wire

// File: rtl/riscv_du_rf_access.sv
////////////////////////////////////////////////////////////////////////////
// Debug access unit for the integer register file
// One access at a time, dbg_ack follows an accepted dbg_req by 3 cycles
// dbg_req seen while busy is dropped
// Stall is high from the cycle after the request through the ack cycle
// Non-GPR addresses are acknowledged, writes ignored, reads return zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module riscv_du_rf_access (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Debugger side
  input  logic                                  dbg_req,
  input  logic                                  dbg_we,
  input  logic [riscv_rf_pkg::DU_ADDR_BITS-1:0] dbg_addr,
  input  logic [riscv_rf_pkg::XLEN-1:0]         dbg_wdata,
  output logic                                  dbg_ack,
  output logic [riscv_rf_pkg::XLEN-1:0]         dbg_rdata,

  // Core hold
  output logic                                  core_stall,

  // Register file debug port
  riscv_du_rf_if.du                             du
);
  import riscv_rf_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////////////////////////////

  du_state_t          state;
  du_state_t          state_nxt;

  // Request accepted this cycle
  logic               req_accept;
  // Address falls in the GPR group
  logic               addr_is_gpr;

  // Latched request
  logic               req_we;
  logic               req_gpr;
  logic [AR_BITS-1:0] req_idx;
  logic [XLEN-1:0]    req_wdata;

  // Shared stall level
  logic               stall;

  //////////////////////////////////////////////////////////////////////////
  // Request decode and latch
  //////////////////////////////////////////////////////////////////////////

  assign req_accept  = (state == DU_IDLE) && dbg_req;

  // Compare everything above the register index
  assign addr_is_gpr = (dbg_addr[DU_ADDR_BITS-1:AR_BITS] ==
                        DU_GPR_BASE[DU_ADDR_BITS-1:AR_BITS]);

  // Payload held for the whole access
  always_ff @(posedge clk) begin
    if (req_accept) begin
      req_we    <= dbg_we;
      req_gpr   <= addr_is_gpr;
      req_idx   <= dbg_addr[AR_BITS-1:0];
      req_wdata <= dbg_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= DU_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Fixed walk once started, one cycle per state
  always_comb begin
    state_nxt = state;
    case (state)
      DU_IDLE:   if (dbg_req) state_nxt = DU_DRAIN;
      DU_DRAIN:  state_nxt = DU_ACCESS;
      DU_ACCESS: state_nxt = DU_ACK;
      DU_ACK:    state_nxt = DU_IDLE;
      default:   state_nxt = DU_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////////

  // Held in drain, access and ack
  assign stall       = (state != DU_IDLE);
  assign core_stall  = stall;
  assign du.du_stall = stall;

  // Strobe only for register addresses
  assign du.du_we_rf = (state == DU_ACCESS) && req_we && req_gpr;
  assign du.du_addr  = req_idx;
  assign du.du_dato  = req_wdata;

  assign dbg_ack     = (state == DU_ACK);

  // Read result taken at the end of the access cycle
  // Kept until the next access completes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dbg_rdata <= '0;
    end else if (state == DU_ACCESS) begin
      dbg_rdata <= req_gpr ? du.du_dati_rf : '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/riscv_rf_top.sv
////////////////////////////////////////////////////////////////////////////
// Register file with debug access, plain ports only
// Adds no latency over the register file and the debug unit
// The core must hold off writes while core_stall is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module riscv_rf_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Core operand reads
  input  logic [riscv_rf_pkg::AR_BITS-1:0]      rf_src1,
  input  logic [riscv_rf_pkg::AR_BITS-1:0]      rf_src2,
  output logic [riscv_rf_pkg::XLEN-1:0]         rf_srcv1,
  output logic [riscv_rf_pkg::XLEN-1:0]         rf_srcv2,

  // Core write-back
  input  logic [riscv_rf_pkg::AR_BITS-1:0]      rf_dst,
  input  logic [riscv_rf_pkg::XLEN-1:0]         rf_dstv,
  input  logic                                  rf_we,

  // Debugger
  input  logic                                  dbg_req,
  input  logic                                  dbg_we,
  input  logic [riscv_rf_pkg::DU_ADDR_BITS-1:0] dbg_addr,
  input  logic [riscv_rf_pkg::XLEN-1:0]         dbg_wdata,
  output logic                                  dbg_ack,
  output logic [riscv_rf_pkg::XLEN-1:0]         dbg_rdata,

  // Hold toward the core pipeline
  output logic                                  core_stall
);

  //////////////////////////////////////////////////////////////////////////
  // Debug port bundle
  //////////////////////////////////////////////////////////////////////////

  riscv_du_rf_if du_bus ();

  // Debug access FSM
  riscv_du_rf_access u_du_access (
    .clk        (clk),
    .rst_n      (rst_n),
    .dbg_req    (dbg_req),
    .dbg_we     (dbg_we),
    .dbg_addr   (dbg_addr),
    .dbg_wdata  (dbg_wdata),
    .dbg_ack    (dbg_ack),
    .dbg_rdata  (dbg_rdata),
    .core_stall (core_stall),
    .du         (du_bus.du)
  );

  // Register array and operand ports
  riscv_rf u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rf_src1  (rf_src1),
    .rf_src2  (rf_src2),
    .rf_srcv1 (rf_srcv1),
    .rf_srcv2 (rf_srcv2),
    .rf_dst   (rf_dst),
    .rf_dstv  (rf_dstv),
    .rf_we    (rf_we),
    .du       (du_bus.rf)
  );

endmodule

`default_nettype wire

// File: verification/riscv_rf_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the register file with debug access
// Shadow array plus a cycle model of the debug unit predict every output
// Operand data, dbg_ack, core_stall and dbg_rdata are compared each cycle
// Registers are all written before any of them is read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module riscv_rf_tb;
  import riscv_rf_pkg::*;

  // Ack wait limit and quiet window after an ignored req
  localparam int ACK_TIMEOUT = 16;

  //////////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////////

  logic                    clk;
  logic                    rst_n;
  logic [AR_BITS-1:0]      rf_src1;
  logic [AR_BITS-1:0]      rf_src2;
  logic [XLEN-1:0]         rf_srcv1;
  logic [XLEN-1:0]         rf_srcv2;
  logic [AR_BITS-1:0]      rf_dst;
  logic [XLEN-1:0]         rf_dstv;
  logic                    rf_we;
  logic                    dbg_req;
  logic                    dbg_we;
  logic [DU_ADDR_BITS-1:0] dbg_addr;
  logic [XLEN-1:0]         dbg_wdata;
  logic                    dbg_ack;
  logic [XLEN-1:0]         dbg_rdata;
  logic                    core_stall;

  riscv_rf_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .rf_src1    (rf_src1),
    .rf_src2    (rf_src2),
    .rf_srcv1   (rf_srcv1),
    .rf_srcv2   (rf_srcv2),
    .rf_dst     (rf_dst),
    .rf_dstv    (rf_dstv),
    .rf_we      (rf_we),
    .dbg_req    (dbg_req),
    .dbg_we     (dbg_we),
    .dbg_addr   (dbg_addr),
    .dbg_wdata  (dbg_wdata),
    .dbg_ack    (dbg_ack),
    .dbg_rdata  (dbg_rdata),
    .core_stall (core_stall)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////////////////////////////

  logic [XLEN-1:0]    shadow [NREGS];
  bit                 written [NREGS];
  // Debug unit phase counts idle drain access ack as 0 to 3
  logic [1:0]         du_phase;
  logic               m_we;
  logic               m_gpr;
  logic [AR_BITS-1:0] m_idx;
  logic [XLEN-1:0]    m_data;
  // Expected outputs for the cycle after the last edge
  logic [XLEN-1:0]    exp_v1;
  logic [XLEN-1:0]    exp_v2;
  logic [XLEN-1:0]    exp_rdata;
  bit                 exp_v1_ok;
  bit                 exp_v2_ok;
  bit                 exp_rdata_ok;
  bit                 model_live;

  // Error counts by source
  int                 mon_errs;
  int                 value_errs;
  int                 other_errs;
  string              test_name;

  // Stimulus state
  logic [15:0]        lfsr;
  bit                 offer_core;
  logic [AR_BITS-1:0] offer_dst;
  logic [XLEN-1:0]    offer_val;
  logic [XLEN-1:0]    v;
  logic [XLEN-1:0]    dv;
  logic [XLEN-1:0]    rd;
  logic [XLEN-1:0]    old_val;
  logic [AR_BITS-1:0] r5;
  logic [DU_ADDR_BITS-1:0] oor;
  int                 lat;
  int                 extra;

  // Expected operand value with x0 hardwired to zero
  function automatic logic [XLEN-1:0] ref_read(input logic [AR_BITS-1:0] a);
    if (a == '0) begin
      return '0;
    end
    return shadow[a];
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [XLEN-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[XLEN-2:0], lfsr[0]};
    end
  endtask

  task automatic draw_reg(output logic [AR_BITS-1:0] idx);
    logic [XLEN-1:0] t;
    draw(AR_BITS, t);
    idx = t[AR_BITS-1:0];
    if (idx == '0) begin
      idx = AR_BITS'(1);
    end
  endtask

  task automatic report_value(input string what, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
    $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    assert (act == exp) else begin
      value_errs++;
      report_value(what, exp, act);
    end
  endtask

  // Advance to just after the next rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic core_write(input logic [AR_BITS-1:0] a, input logic [XLEN-1:0] d);
    rf_we   = 1'b1;
    rf_dst  = a;
    rf_dstv = d;
    step();
    rf_we   = 1'b0;
  endtask

  task automatic core_read(input logic [AR_BITS-1:0] a, input logic [AR_BITS-1:0] b);
    rf_src1 = a;
    rf_src2 = b;
    step();
  endtask

  // Entered one cycle after the accepting edge and counts cycles from there
  task automatic wait_ack(output int cycles);
    cycles = 1;
    while (dbg_ack !== 1'b1 && cycles <= ACK_TIMEOUT) begin
      assert (core_stall) else begin
        value_errs++;
        report_value("core_stall while waiting", 1, XLEN'(core_stall));
      end
      // Core keeps writing through the stall in the collision case
      if (offer_core) begin
        rf_we   = 1'b1;
        rf_dst  = offer_dst;
        rf_dstv = offer_val;
        rf_src1 = offer_dst;
      end
      step();
      cycles++;
    end
    if (dbg_ack !== 1'b1) begin
      other_errs++;
      $display("timeout in %s: no dbg_ack within %0d cycles", test_name, ACK_TIMEOUT);
    end
  endtask

  // Full access that returns with the unit idle again
  task automatic dbg_access(input logic we, input logic [DU_ADDR_BITS-1:0] addr,
                            input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
    int cycles;
    dbg_req   = 1'b1;
    dbg_we    = we;
    dbg_addr  = addr;
    dbg_wdata = wdata;
    step();
    dbg_req   = 1'b0;
    wait_ack(cycles);
    check_value("ack latency", 3, XLEN'(cycles));
    assert (core_stall) else begin
      value_errs++;
      report_value("core_stall in ack cycle", 1, XLEN'(core_stall));
    end
    rdata = dbg_rdata;
    if (offer_core) begin
      rf_we = 1'b1;
    end
    step();
    rf_we = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Cycle model updated at every rising edge
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    // Reads see the array as it was before this edge
    exp_v1    = ref_read(rf_src1);
    exp_v2    = ref_read(rf_src2);
    exp_v1_ok = (rf_src1 == '0) || written[rf_src1];
    exp_v2_ok = (rf_src2 == '0) || written[rf_src2];
    if (!rst_n) begin
      du_phase     = 2'd0;
      exp_rdata    = '0;
      exp_rdata_ok = 1'b1;
      exp_v1       = '0;
      exp_v2       = '0;
      exp_v1_ok    = 1'b1;
      exp_v2_ok    = 1'b1;
    end else begin
      if (du_phase == 2'd2) begin
        exp_rdata    = m_gpr ? ref_read(m_idx) : '0;
        exp_rdata_ok = !m_gpr || (m_idx == '0) || written[m_idx];
      end
      // Debug write beats the core write
      if (du_phase == 2'd2 && m_we && m_gpr) begin
        shadow[m_idx]  = m_data;
        written[m_idx] = 1'b1;
      end else if (rf_we) begin
        shadow[rf_dst]  = rf_dstv;
        written[rf_dst] = 1'b1;
      end
      if (du_phase == 2'd0) begin
        if (dbg_req) begin
          du_phase = 2'd1;
          m_we     = dbg_we;
          // GPR window 0x000..0x01F
          m_gpr    = (dbg_addr[DU_ADDR_BITS-1:AR_BITS] == '0);
          m_idx    = dbg_addr[AR_BITS-1:0];
          m_data   = dbg_wdata;
        end
      end else begin
        du_phase = du_phase + 2'd1;
      end
    end
    model_live = 1'b1;
  end

  // Compare in mid cycle once outputs have settled
  always @(negedge clk) begin
    if (model_live) begin
      if (exp_v1_ok) begin
        assert (rf_srcv1 == exp_v1) else begin
          mon_errs++;
          report_value("rf_srcv1", exp_v1, rf_srcv1);
        end
      end
      if (exp_v2_ok) begin
        assert (rf_srcv2 == exp_v2) else begin
          mon_errs++;
          report_value("rf_srcv2", exp_v2, rf_srcv2);
        end
      end
      assert (dbg_ack == (du_phase == 2'd3)) else begin
        mon_errs++;
        report_value("dbg_ack", XLEN'(du_phase == 2'd3), XLEN'(dbg_ack));
      end
      assert (core_stall == (du_phase != 2'd0)) else begin
        mon_errs++;
        report_value("core_stall", XLEN'(du_phase != 2'd0), XLEN'(core_stall));
      end
      if (exp_rdata_ok) begin
        assert (dbg_rdata == exp_rdata) else begin
          mon_errs++;
          report_value("dbg_rdata", exp_rdata, dbg_rdata);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    rf_src1    = '0;
    rf_src2    = '0;
    rf_dst     = '0;
    rf_dstv    = '0;
    rf_we      = 1'b0;
    dbg_req    = 1'b0;
    dbg_we     = 1'b0;
    dbg_addr   = '0;
    dbg_wdata  = '0;
    lfsr       = 16'd61;
    offer_core = 1'b0;
    offer_dst  = '0;
    offer_val  = '0;
    model_live = 1'b0;
    du_phase   = 2'd0;
    mon_errs   = 0;
    value_errs = 0;
    other_errs = 0;
    test_name  = "reset";
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("dbg_ack", 0, XLEN'(dbg_ack));
    check_value("core_stall", 0, XLEN'(core_stall));
    check_value("dbg_rdata", 0, dbg_rdata);

    // Fill every register, then read all on both ports
    test_name = "write_all";
    for (int r = 0; r < NREGS; r++) begin
      draw(XLEN, v);
      core_write(r[AR_BITS-1:0], v);
    end
    test_name = "read_all";
    for (int r = 0; r < NREGS; r++) begin
      core_read(r[AR_BITS-1:0], AR_BITS'(NREGS - 1 - r));
    end
    step();

    // Same-edge read sees old data without bypass
    test_name = "read_during_write";
    draw_reg(r5);
    old_val = ref_read(r5);
    draw(XLEN, v);
    rf_src1 = r5;
    rf_src2 = r5;
    core_write(r5, v);
    check_value("same-edge read", old_val, rf_srcv1);
    step();
    check_value("next-edge read", v, rf_srcv2);

    test_name = "dbg_write_read";
    draw_reg(r5);
    draw(XLEN, dv);
    dbg_access(1'b1, DU_ADDR_BITS'(r5), dv, rd);
    core_read(r5, '0);
    check_value("core read after debug write", dv, rf_srcv1);
    draw_reg(r5);
    old_val = ref_read(r5);
    dbg_access(1'b0, DU_ADDR_BITS'(r5), '0, rd);
    check_value("debug read", old_val, rd);
    dbg_access(1'b0, '0, '0, rd);
    check_value("debug read x0", '0, rd);

    // Core write offered through the whole stall
    test_name = "dbg_core_collision";
    draw_reg(r5);
    draw(XLEN, dv);
    draw(XLEN, v);
    offer_core = 1'b1;
    offer_dst  = r5;
    offer_val  = v;
    dbg_access(1'b1, DU_ADDR_BITS'(r5), dv, rd);
    offer_core = 1'b0;
    check_value("read sampled in ack cycle", dv, rf_srcv1);
    step();

    test_name = "dbg_out_of_range";
    draw(DU_ADDR_BITS, v);
    oor = v[DU_ADDR_BITS-1:0] | 12'h020;
    // Nonzero index bits so a stray write or read would show
    if (oor[AR_BITS-1:0] == '0) begin
      oor[0] = 1'b1;
    end
    draw(XLEN, dv);
    dbg_access(1'b1, oor, dv, rd);
    for (int r = 0; r < NREGS; r++) begin
      core_read(r[AR_BITS-1:0], r[AR_BITS-1:0]);
    end
    step();
    dbg_access(1'b0, oor, '0, rd);
    check_value("out-of-range read", '0, rd);

    // Request held into the drain cycle must be dropped
    test_name = "dbg_busy";
    draw_reg(r5);
    dbg_req  = 1'b1;
    dbg_we   = 1'b0;
    dbg_addr = DU_ADDR_BITS'(r5);
    step();
    dbg_addr = '0;
    step();
    dbg_req = 1'b0;
    wait_ack(lat);
    // Wait entered two cycles after the accepting edge
    check_value("ack latency after held request", 2, XLEN'(lat));
    step();
    extra = 0;
    repeat (ACK_TIMEOUT) begin
      if (dbg_ack) begin
        extra++;
      end
      step();
    end
    assert (extra == 0) else begin
      other_errs++;
      $display("%s: %0d extra dbg_ack pulses after an ignored request", test_name, extra);
    end

    step();
    $display("errors: monitor %0d, direct %0d, other %0d", mon_errs, value_errs, other_errs);
    if (mon_errs + value_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/riscv_rf_pkg.sv
rtl/riscv_du_rf_if.sv
rtl/riscv_rf.sv
rtl/riscv_du_rf_access.sv
rtl/riscv_rf_top.sv
verification/riscv_rf_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the register file testbench with Verilator.
# Exit status is zero only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module riscv_rf_tb -Mdir obj_dir -o riscv_rf_sim -f files.f; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/riscv_rf_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -Fqx '** PASS **'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
